// ==== flist.f ====
logic/mel_pkg.sv
logic/mel_bin_if.sv
logic/bin_power.sv
logic/mel_weight_rom.sv
logic/mel_filterbank.sv
logic/log2_compress.sv
logic/mel_frontend_top.sv
tests/mel_frontend_props.sv
tests/mel_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: mel_frontend

sources:
  # Design sources in compile order
  - logic/mel_pkg.sv
  - logic/mel_bin_if.sv
  - logic/bin_power.sv
  - logic/mel_weight_rom.sv
  - logic/mel_filterbank.sv
  - logic/log2_compress.sv
  - logic/mel_frontend_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/mel_frontend_props.sv
      - tests/mel_frontend_tb.sv

// ==== tests/mel_frontend_tb.sv ====
`timescale 1ns/1ps

module mel_frontend_tb import mel_pkg::*; ();

    localparam int SAMPLE_W      = 16;
    localparam int SEED          = 45947;
    localparam int RESET_CYCLES  = 5;
    localparam int LATENCY       = 4;
    localparam int MAX_GAP       = 4;
    localparam int FULL_FRAMES   = 2;
    localparam int RAND_FRAMES   = 20;
    localparam int GAP_FRAMES    = 6;
    localparam int ZERO_FRAMES   = 1;
    localparam int SINGLE_FRAMES = 4;
    localparam int SPREAD_FRAMES = 6;
    localparam int RESET_BINS    = 20;
    localparam int TOTAL_FRAMES  = FULL_FRAMES + RAND_FRAMES + GAP_FRAMES + ZERO_FRAMES
                                 + SINGLE_FRAMES + SPREAD_FRAMES + 2;
    // Every bin may carry a full gap, plus resets and pipeline drains
    localparam int STIM_CYCLES   = TOTAL_FRAMES * NUM_BINS * (MAX_GAP + 1) + 200;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 100;

    typedef struct packed {
        logic [FILT_W-1:0] index;
        logic [63:0]       energy;
        logic [LOG_W-1:0]  log_val;
        logic [31:0]       due;
    } expect_t;

    logic                       clk;
    logic                       rst_n;
    logic                       bin_valid;
    logic signed [SAMPLE_W-1:0] bin_re;
    logic signed [SAMPLE_W-1:0] bin_im;
    logic                       mel_valid;
    logic [FILT_W-1:0]          mel_index;
    logic [ACC_W-1:0]           mel_energy;
    logic [LOG_W-1:0]           mel_log;

    expect_t     exp_q[$];
    longint      model_acc [NUM_FILTERS];
    int          model_bin_idx;
    int unsigned cycle;
    int unsigned seed_val;
    int          mismatch_count;
    int          other_errors;
    int          checked_count;

    mel_frontend_top #(
        .SAMPLE_W (SAMPLE_W)
    ) i_mel_frontend_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .bin_valid  (bin_valid),
        .bin_re     (bin_re),
        .bin_im     (bin_im),
        .mel_valid  (mel_valid),
        .mel_index  (mel_index),
        .mel_energy (mel_energy),
        .mel_log    (mel_log)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles with %0d outputs still expected",
                     TIMEOUT_CYCLES, exp_q.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Leading-one position, then the 10 bits just below it
    function automatic logic [LOG_W-1:0] expected_log(input longint e);
        int                          lead;
        logic [63:0]                 bits;
        logic [63:0]                 frac;
        logic [LOG_W-LOG_FRAC_W-1:0] ipart;
        bits = e;
        lead = 0;
        for (int i = 0; i < 64; i++) begin
            if (bits[i]) begin
                lead = i;
            end
        end
        if (lead >= LOG_FRAC_W) begin
            frac = bits >> (lead - LOG_FRAC_W);
        end else begin
            frac = bits << (LOG_FRAC_W - lead);
        end
        ipart = lead[LOG_W-LOG_FRAC_W-1:0];
        if (bits == 0) begin
            return '0;
        end
        return {ipart, frac[LOG_FRAC_W-1:0]};
    endfunction

    task automatic clear_model();
        model_bin_idx = 0;
        for (int m = 0; m < NUM_FILTERS; m++) begin
            model_acc[m] = 0;
        end
    endtask

    // Reference model of one bin, queues every filter this bin completes
    task automatic model_bin(input logic signed [SAMPLE_W-1:0] re,
                             input logic signed [SAMPLE_W-1:0] im);
        longint  sre;
        longint  sim;
        longint  pwr;
        longint  up;
        int      seg;
        int      span;
        expect_t item;
        sre = re;
        sim = im;
        pwr = sre * sre + sim * sim;
        seg = 0;
        for (int j = 0; j < NUM_FILTERS + 1; j++) begin
            if (model_bin_idx >= MEL_EDGES[j]) begin
                seg = j;
            end
        end
        span = MEL_EDGES[seg + 1] - MEL_EDGES[seg];
        up = (longint'(model_bin_idx - MEL_EDGES[seg]) * 32768) / span;
        if (seg < NUM_FILTERS) begin
            model_acc[seg] += pwr * up;
        end
        if (seg >= 1) begin
            model_acc[seg - 1] += pwr * (32768 - up);
        end
        for (int m = 0; m < NUM_FILTERS; m++) begin
            if (model_bin_idx == MEL_EDGES[m + 2] - 1) begin
                item.index   = m[FILT_W-1:0];
                item.energy  = model_acc[m];
                item.log_val = expected_log(model_acc[m]);
                item.due     = cycle + LATENCY;
                exp_q.push_back(item);
            end
        end
        model_bin_idx++;
        if (model_bin_idx == NUM_BINS) begin
            clear_model();
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            bin_valid = 1'b0;
        end
    endtask

    // Gap cycles carry junk data with the strobe low
    task automatic send_bin(input logic signed [SAMPLE_W-1:0] re,
                            input logic signed [SAMPLE_W-1:0] im, input int gap);
        for (int i = 0; i < gap; i++) begin
            @(posedge clk);
            #1;
            bin_valid = 1'b0;
            bin_re    = $urandom;
            bin_im    = $urandom;
        end
        @(posedge clk);
        #1;
        bin_valid = 1'b1;
        bin_re    = re;
        bin_im    = im;
        model_bin(re, im);
    endtask

    task automatic send_frame_const(input logic signed [SAMPLE_W-1:0] re,
                                    input logic signed [SAMPLE_W-1:0] im);
        for (int b = 0; b < NUM_BINS; b++) begin
            send_bin(re, im, 0);
        end
    endtask

    task automatic run_random_frames(input int frames, input int max_gap);
        logic signed [SAMPLE_W-1:0] r;
        logic signed [SAMPLE_W-1:0] i;
        int                         gap;
        repeat (frames * NUM_BINS) begin
            r   = $urandom;
            i   = $urandom;
            gap = 0;
            if (max_gap > 0 && $urandom_range(0, 2) == 0) begin
                gap = $urandom_range(1, max_gap);
            end
            send_bin(r, i, gap);
        end
    endtask

    // Only bin k carries power
    task automatic run_single_bin(input int k);
        logic signed [SAMPLE_W-1:0] r;
        logic signed [SAMPLE_W-1:0] i;
        r = $urandom_range(1, 32767);
        i = $urandom;
        for (int b = 0; b < NUM_BINS; b++) begin
            if (b == k) begin
                send_bin(r, i, 0);
            end else begin
                send_bin('0, '0, 0);
            end
        end
    endtask

    // Frame amplitude scaled down by a random shift
    task automatic run_spread_frame(input int shift);
        logic signed [SAMPLE_W-1:0] r;
        logic signed [SAMPLE_W-1:0] i;
        for (int b = 0; b < NUM_BINS; b++) begin
            r = $urandom;
            i = $urandom;
            send_bin(r >>> shift, i >>> shift, 0);
        end
    endtask

    task automatic wait_drain();
        idle(1);
        while (exp_q.size() != 0) begin
            idle(1);
        end
    endtask

    task automatic apply_reset(input bit check_outputs);
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        bin_valid = 1'b0;
        clear_model();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (check_outputs) begin
                check_value("mel_valid", mel_valid, '0);
                check_value("mel_index", mel_index, '0);
                check_value("mel_energy", mel_energy, '0);
                check_value("mel_log", mel_log, '0);
            end
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // Outputs sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        expect_t head;
        if (rst_n && mel_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Output for filter %0d arrived with no expected entry at %0t",
                         mel_index, $time);
            end else begin
                head = exp_q.pop_front();
                checked_count++;
                check_value("mel_index", mel_index, head.index);
                check_value("mel_energy", mel_energy, head.energy);
                check_value("mel_log", mel_log, head.log_val);
                check_value("mel_valid cycle", cycle, head.due);
            end
        end
    end

    initial begin
        seed_val       = $urandom(SEED);
        cycle          = 0;
        mismatch_count = 0;
        other_errors   = 0;
        checked_count  = 0;
        rst_n          = 1'b0;
        bin_valid      = 1'b0;
        bin_re         = '0;
        bin_im         = '0;
        apply_reset(1'b0);

        repeat (FULL_FRAMES) begin
            send_frame_const(16'sh8000, 16'sh8000);
        end
        run_random_frames(RAND_FRAMES, 0);
        run_random_frames(GAP_FRAMES, MAX_GAP);
        repeat (ZERO_FRAMES) begin
            send_frame_const('0, '0);
        end
        repeat (SINGLE_FRAMES) begin
            run_single_bin($urandom_range(0, NUM_BINS - 1));
        end
        repeat (SPREAD_FRAMES) begin
            run_spread_frame($urandom_range(0, SAMPLE_W - 1));
        end

        // Reset part way into a frame, then a clean frame from bin 0
        for (int b = 0; b < RESET_BINS; b++) begin
            send_bin($urandom, $urandom, 0);
        end
        wait_drain();
        apply_reset(1'b1);
        run_random_frames(1, 0);

        wait_drain();
        idle(10);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Run ended with %0d expected outputs never seen", exp_q.size());
        end
        $display("Summary: %0d outputs checked, %0d value mismatches, %0d other errors",
                 checked_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/mel_frontend_props.sv ====
`timescale 1ns/1ps

module mel_frontend_props import mel_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input logic [BIN_W-1:0]  in_bin,
    input logic              in_seg_last,
    input logic              energy_valid,
    input logic [FILT_W-1:0] energy_index
);

    logic [FILT_W-1:0] prev_index;
    logic              seen_strobe;

    // Last emitted filter index since reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_index  <= '0;
            seen_strobe <= 1'b0;
        end else if (energy_valid) begin
            prev_index  <= energy_index;
            seen_strobe <= 1'b1;
        end
    end

    single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        energy_valid |=> !energy_valid)
        else $error("energy_valid high on two consecutive cycles");

    index_order: assert property (@(posedge clk) disable iff (!rst_n)
        energy_valid |-> energy_index == (seen_strobe ? FILT_W'(prev_index + 1'b1) : '0))
        else $error("energy_index %0d out of order after %0d", energy_index, prev_index);

    // Segment 0 ends with no finished filter
    seg_end_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && in_seg_last && in_bin >= BIN_W'(MEL_EDGES[1])) |-> ##2 energy_valid)
        else $error("energy_valid missing two cycles after segment end");

endmodule

bind mel_filterbank mel_frontend_props i_mel_frontend_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in.valid),
    .in_bin       (in.bin),
    .in_seg_last  (in.seg_last),
    .energy_valid (energy_valid),
    .energy_index (energy_index)
);

// ==== logic/mel_frontend_top.sv ====
`timescale 1ns/1ps

module mel_frontend_top import mel_pkg::*; #(
    parameter int SAMPLE_W = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // DFT bins, one per strobe, index order 0 to 63
    input  logic                       bin_valid,
    input  logic signed [SAMPLE_W-1:0] bin_re,
    input  logic signed [SAMPLE_W-1:0] bin_im,

    // Filter energies, filter order 0 to 7
    output logic                       mel_valid,
    output logic [FILT_W-1:0]          mel_index,
    output logic [ACC_W-1:0]           mel_energy,
    output logic [LOG_W-1:0]           mel_log
);

    logic              fb_valid;
    logic [FILT_W-1:0] fb_index;
    logic [ACC_W-1:0]  fb_energy;

    mel_bin_if bin_bus ();

    bin_power #(
        .SAMPLE_W (SAMPLE_W)
    ) i_bin_power (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (bin_valid),
        .re       (bin_re),
        .im       (bin_im),
        .out      (bin_bus.src)
    );

    mel_filterbank i_mel_filterbank (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (bin_bus.dst),
        .energy_valid (fb_valid),
        .energy_index (fb_index),
        .energy       (fb_energy)
    );

    log2_compress i_log2_compress (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (fb_valid),
        .in_index   (fb_index),
        .in_energy  (fb_energy),
        .out_valid  (mel_valid),
        .out_index  (mel_index),
        .out_energy (mel_energy),
        .out_log    (mel_log)
    );

endmodule

// ==== logic/log2_compress.sv ====
`timescale 1ns/1ps

module log2_compress import mel_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic [FILT_W-1:0] in_index,
    input  logic [ACC_W-1:0]  in_energy,
    output logic              out_valid,
    output logic [FILT_W-1:0] out_index,
    output logic [ACC_W-1:0]  out_energy,
    output logic [LOG_W-1:0]  out_log
);

    // Integer bits of the Q6.10 result
    localparam int INT_W = LOG_W - LOG_FRAC_W;

    logic [INT_W-1:0]      lead_pos;
    logic [ACC_W-1:0]      norm;
    logic [LOG_FRAC_W-1:0] frac;

    // Priority scan, highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < ACC_W; i++) begin
            if (in_energy[i]) begin
                lead_pos = INT_W'(i);
            end
        end
    end

    // Shift the leading one to the MSB, zeros fill in below short values
    assign norm = in_energy << (ACC_W - 1 - lead_pos);
    assign frac = norm[ACC_W-2 -: LOG_FRAC_W];

    // Zero energy gives lead_pos 0 and an all-zero norm, hence log 0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_index  <= '0;
            out_energy <= '0;
            out_log    <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_index  <= in_index;
                out_energy <= in_energy;
                out_log    <= {lead_pos, frac};
            end
        end
    end

endmodule

// ==== logic/mel_filterbank.sv ====
`timescale 1ns/1ps

module mel_filterbank import mel_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    mel_bin_if.dst            in,
    output logic              energy_valid,
    output logic [FILT_W-1:0] energy_index,
    output logic [ACC_W-1:0]  energy
);

    // Segment past the last rising edge, only falling slopes live here
    localparam logic [SEG_W-1:0] LAST_SEG = SEG_W'(NUM_FILTERS);

    logic [WEIGHT_W-1:0] up_weight;
    logic [WEIGHT_W-1:0] dn_weight;
    logic [SEG_W-1:0]    rom_seg;

    logic                s1_valid;
    logic                s1_last;
    logic [SEG_W-1:0]    s1_seg;
    logic [PROD_W-1:0]   s1_up_prod;
    logic [PROD_W-1:0]   s1_dn_prod;

    logic [ACC_W-1:0]    rise_acc;
    logic [ACC_W-1:0]    fall_acc;
    logic [ACC_W-1:0]    rise_sum;
    logic [ACC_W-1:0]    fall_sum;
    logic                rise_used;
    logic                fall_used;

    mel_weight_rom i_weight_rom (
        .bin       (in.bin),
        .up_weight (up_weight),
        .seg       (rom_seg)
    );

    // Up weight never reaches unity, so this stays within 16 bits
    assign dn_weight = WEIGHT_W'(UNITY_WEIGHT) - up_weight;

    // Stage 1: weighted products
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            s1_seg   <= '0;
        end else begin
            s1_valid <= in.valid;
            if (in.valid) begin
                s1_last <= in.seg_last;
                s1_seg  <= rom_seg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            s1_up_prod <= in.power * up_weight;
            s1_dn_prod <= in.power * dn_weight;
        end
    end

    // Filter j-1 falls and filter j rises over segment j
    assign rise_used = (s1_seg != LAST_SEG);
    assign fall_used = (s1_seg != '0);
    assign rise_sum  = rise_used ? rise_acc + ACC_W'(s1_up_prod) : rise_acc;
    assign fall_sum  = fall_used ? fall_acc + ACC_W'(s1_dn_prod) : fall_acc;

    // Stage 2: accumulate and hand off at segment ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rise_acc     <= '0;
            fall_acc     <= '0;
            energy_valid <= 1'b0;
            energy_index <= '0;
            energy       <= '0;
        end else begin
            energy_valid <= 1'b0;
            if (s1_valid) begin
                if (s1_last) begin
                    if (fall_used) begin
                        energy_valid <= 1'b1;
                        energy_index <= FILT_W'(s1_seg - 1'b1);
                        energy       <= fall_sum;
                    end
                    rise_acc <= '0;
                    // At frame end the rising slot is idle, so both clear
                    fall_acc <= rise_used ? rise_sum : '0;
                end else begin
                    rise_acc <= rise_sum;
                    fall_acc <= fall_sum;
                end
            end
        end
    end

endmodule

// ==== logic/mel_weight_rom.sv ====
`timescale 1ns/1ps

module mel_weight_rom import mel_pkg::*; (
    input  logic [BIN_W-1:0]    bin,
    output logic [WEIGHT_W-1:0] up_weight,
    output logic [SEG_W-1:0]    seg
);

    typedef logic [NUM_BINS-1:0][WEIGHT_W-1:0] weight_table_t;
    typedef logic [NUM_BINS-1:0][SEG_W-1:0]    seg_table_t;

    function automatic weight_table_t build_weight_table();
        weight_table_t t;
        for (int b = 0; b < NUM_BINS; b++) begin
            t[b] = mel_up_weight(b, mel_seg_of(b));
        end
        return t;
    endfunction

    function automatic seg_table_t build_seg_table();
        seg_table_t t;
        for (int b = 0; b < NUM_BINS; b++) begin
            t[b] = SEG_W'(mel_seg_of(b));
        end
        return t;
    endfunction

    // Both tables are constants, evaluated at elaboration
    localparam weight_table_t UP_TABLE  = build_weight_table();
    localparam seg_table_t    SEG_TABLE = build_seg_table();

    assign up_weight = UP_TABLE[bin];
    assign seg       = SEG_TABLE[bin];

endmodule

// ==== logic/bin_power.sv ====
`timescale 1ns/1ps

module bin_power import mel_pkg::*; #(
    parameter int SAMPLE_W = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] re,
    input  logic signed [SAMPLE_W-1:0] im,
    mel_bin_if.src                     out
);

    localparam int SQ_W = 2 * SAMPLE_W;

    logic signed [SQ_W-1:0] re_sq;
    logic signed [SQ_W-1:0] im_sq;
    logic [SQ_W:0]          power_sum;
    logic [BIN_W-1:0]       bin_cnt;
    logic [BIN_W:0]         next_bin;
    logic                   at_edge;

    assign re_sq = re * re;
    assign im_sq = im * im;

    // Both squares are non-negative, so add them unsigned
    assign power_sum = {1'b0, re_sq} + {1'b0, im_sq};

    // One bit wider so that bin 63 sees next index 64
    assign next_bin = {1'b0, bin_cnt} + 1'b1;

    always_comb begin
        at_edge = 1'b0;
        for (int j = 1; j < NUM_EDGES; j++) begin
            if (int'(next_bin) == MEL_EDGES[j]) begin
                at_edge = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bin_cnt      <= '0;
            out.valid    <= 1'b0;
            out.bin      <= '0;
            out.seg_last <= 1'b0;
        end else begin
            out.valid <= in_valid;
            if (in_valid) begin
                out.bin      <= bin_cnt;
                out.seg_last <= at_edge || (bin_cnt == BIN_W'(NUM_BINS - 1));
                // Wraps to bin 0 after bin 63
                bin_cnt      <= bin_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out.power <= POWER_W'(power_sum);
        end
    end

endmodule

// ==== logic/mel_bin_if.sv ====
`timescale 1ns/1ps

interface mel_bin_if import mel_pkg::*; ();

    logic               valid;
    logic [BIN_W-1:0]   bin;
    logic [POWER_W-1:0] power;
    // High on the last bin of each segment
    logic               seg_last;

    modport src (
        output valid,
        output bin,
        output power,
        output seg_last
    );

    modport dst (
        input valid,
        input bin,
        input power,
        input seg_last
    );

endinterface

// ==== logic/mel_pkg.sv ====
package mel_pkg;

    // Frame and filterbank geometry
    localparam int NUM_BINS    = 64;
    localparam int BIN_W       = 6;
    localparam int NUM_FILTERS = 8;
    localparam int FILT_W      = 3;
    localparam int NUM_EDGES   = NUM_FILTERS + 2;
    localparam int SEG_W       = 4;

    // Datapath widths
    localparam int POWER_W      = 32;
    localparam int WEIGHT_W     = 16;
    localparam int UNITY_WEIGHT = 32768;
    localparam int PROD_W       = POWER_W + WEIGHT_W;
    localparam int ACC_W        = 56;
    localparam int LOG_W        = 16;
    localparam int LOG_FRAC_W   = 10;

    // Mel-spaced triangle edges, in bins
    localparam int MEL_EDGES [NUM_EDGES] = '{0, 2, 4, 7, 11, 16, 23, 32, 45, 64};

    // Segment j holds bins from edge j up to edge j+1, exclusive
    function automatic int mel_seg_of(int b);
        int seg;
        seg = 0;
        for (int j = 1; j < NUM_EDGES - 1; j++) begin
            if (b >= MEL_EDGES[j]) begin
                seg = j;
            end
        end
        return seg;
    endfunction

    // Rising weight of bin b inside segment seg, floor division
    function automatic logic [WEIGHT_W-1:0] mel_up_weight(int b, int seg);
        int span;
        int offs;
        span = MEL_EDGES[seg + 1] - MEL_EDGES[seg];
        offs = b - MEL_EDGES[seg];
        return WEIGHT_W'((offs * UNITY_WEIGHT) / span);
    endfunction

endpackage
